//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_pkg.sv
  - pipe_reg.sv
  - fetch_unit.sv
  - decode_unit.sv
  - execute_unit.sv
  - data_memory.sv
  - pipe_control.sv
  - rv_core.sv
  - target: test
    files:
      - tb_rv_core.sv

//--- data_memory.sv
// word-addressed data memory, clocked write and combinational read
`default_nettype none

`include "rv_defines.svh"

module data_memory #(
    parameter int depth = `DMEM_WORDS
) (
    input  wire               clk,
    input  wire               we,
    input  wire [`XLEN-1:0]   addr,  // byte address
    input  wire [`XLEN-1:0]   wdata,
    output logic [`XLEN-1:0]  rdata
);

    localparam int IDX_W = $clog2(depth);

    logic [`XLEN-1:0] mem [depth];
    logic [IDX_W-1:0] idx;

    assign idx = addr[IDX_W+1:2]; // byte offset dropped, upper bits wrap

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- decode_unit.sv
// instruction decoder, immediate generator and 32-entry register file
`default_nettype none

`include "rv_defines.svh"

module decode_unit (
    input  wire            clk,
    input  wire            reset,
    input  rv_pkg::if_id_t  if_id,
    input  rv_pkg::mem_wb_t wb,
    output rv_pkg::id_ex_t  id_ex
);
    import rv_pkg::*;

    localparam int NUM_REGS = 2 ** `REG_ADDR_W;

    logic [`XLEN-1:0]       regs [NUM_REGS];
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_s;
    logic [`XLEN-1:0]       imm_b;
    logic [`XLEN-1:0]       imm;
    logic                   wr_en;
    ctrl_t                  ctrl;

    assign opcode = if_id.inst[6:0];
    assign funct3 = if_id.inst[14:12];
    assign rs1    = if_id.inst[19:15];
    assign rs2    = if_id.inst[24:20];

    assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
    assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                    if_id.inst[30:25], if_id.inst[11:8], 1'b0};

    // alt selects sub over add and sra over srl
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            `F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:  op = ALU_SLL;
            `F3_SLT:  op = ALU_SLT;
            `F3_SLTU: op = ALU_SLTU;
            `F3_XOR:  op = ALU_XOR;
            `F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:   op = ALU_OR;
            default:  op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0; // unknown opcodes decode as no-op
        imm  = imm_i;
        case (opcode)
            `OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_f3(funct3, if_id.inst[30]);
            end
            `OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                // bit 30 is part of the immediate except on srai
                ctrl.alu_op    = alu_from_f3(funct3, if_id.inst[30] && funct3 == `F3_SR);
            end
            `OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            `OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm            = imm_s;
            end
            `OPC_BRANCH: begin
                ctrl.branch    = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
                ctrl.branch_ne = (funct3 == `F3_BNE);
                imm            = imm_b;
            end
            `OPC_SYSTEM: begin
                ctrl.is_ecall = (if_id.inst[31:7] == '0); // ebreak and csr ignored
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // register file, x0 never written
    assign wr_en = wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.wb_data;
        end
    end

    // same-cycle write is seen by the read
    assign id_ex.rs1_data = (rs1 == '0) ? '0 :
                            (wr_en && wb.rd == rs1) ? wb.wb_data : regs[rs1];
    assign id_ex.rs2_data = (rs2 == '0) ? '0 :
                            (wr_en && wb.rd == rs2) ? wb.wb_data : regs[rs2];

    assign id_ex.ctrl = ctrl;
    assign id_ex.pc   = if_id.pc;
    assign id_ex.imm  = imm;
    assign id_ex.rs1  = rs1;
    assign id_ex.rs2  = rs2;
    assign id_ex.rd   = if_id.inst[11:7];

    no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.mem_read && ctrl.mem_write))
        else $error("decoded both mem_read and mem_write, inst %h", if_id.inst);

endmodule

`default_nettype wire

//--- execute_unit.sv
// operand forwarding muxes, alu and beq/bne resolution
`default_nettype none

`include "rv_defines.svh"

module execute_unit (
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::fwd_sel_e  fwd_a,
    input  rv_pkg::fwd_sel_e  fwd_b,
    input  wire [`XLEN-1:0]   mem_fwd,
    input  wire [`XLEN-1:0]   wb_fwd,
    output rv_pkg::ex_mem_t   ex_mem,
    output logic              branch_taken,
    output logic [`XLEN-1:0]  branch_target
);
    import rv_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b_reg;  // rs2 after forwarding, also the store data
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   alu_out;
    logic [SHAMT_W-1:0] shamt;
    logic               equal;

    function automatic logic [`XLEN-1:0] pick(input fwd_sel_e sel,
                                              input logic [`XLEN-1:0] rf_val,
                                              input logic [`XLEN-1:0] mem_val,
                                              input logic [`XLEN-1:0] wb_val);
        logic [`XLEN-1:0] val;
        case (sel)
            FWD_MEM: val = mem_val;
            FWD_WB:  val = wb_val;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    assign op_a     = pick(fwd_a, id_ex.rs1_data, mem_fwd, wb_fwd);
    assign op_b_reg = pick(fwd_b, id_ex.rs2_data, mem_fwd, wb_fwd);
    assign op_b     = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;
    assign shamt    = op_b[SHAMT_W-1:0];

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << shamt;
            ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> shamt;
            ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
            ALU_OR:   alu_out = op_a | op_b;
            default:  alu_out = op_a & op_b;
        endcase
    end

    // branches compare the two registers, never the immediate
    assign equal         = (op_a == op_b_reg);
    assign branch_taken  = id_ex.ctrl.branch && (id_ex.ctrl.branch_ne ? !equal : equal);
    assign branch_target = id_ex.pc + id_ex.imm;

    assign ex_mem.reg_write  = id_ex.ctrl.reg_write;
    assign ex_mem.mem_read   = id_ex.ctrl.mem_read;
    assign ex_mem.mem_write  = id_ex.ctrl.mem_write;
    assign ex_mem.is_ecall   = id_ex.ctrl.is_ecall;
    assign ex_mem.alu_out    = alu_out;
    assign ex_mem.store_data = op_b_reg;
    assign ex_mem.rd         = id_ex.rd;

endmodule

`default_nettype wire

//--- fetch_unit.sv
// program counter, next-pc select and the instruction fetch port
`default_nettype none

`include "rv_defines.svh"

module fetch_unit (
    input  wire               clk,
    input  wire               reset,
    input  wire               stall,
    input  wire               halted,
    input  wire               branch_taken,
    input  wire [`XLEN-1:0]   branch_target,
    output logic [`XLEN-1:0]  imem_addr,
    input  wire [`XLEN-1:0]   imem_data,
    output rv_pkg::if_id_t    if_id
);
    import rv_pkg::*;

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;

    always_comb begin
        if (halted) begin
            pc_next = pc; // frozen for good
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign imem_addr  = pc;
    assign if_id.pc   = pc;
    assign if_id.inst = imem_data; // imem answers in the same cycle

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- pipe_control.sv
// load-use hazard detection, forwarding select, stall and flush generation
`default_nettype none

`include "rv_defines.svh"

module pipe_control (
    input  wire                    clk,
    input  wire                    reset,
    input  wire [`REG_ADDR_W-1:0]  id_rs1,
    input  wire [`REG_ADDR_W-1:0]  id_rs2,
    input  wire [`REG_ADDR_W-1:0]  ex_rs1,
    input  wire [`REG_ADDR_W-1:0]  ex_rs2,
    input  wire [`REG_ADDR_W-1:0]  ex_rd,
    input  wire [`REG_ADDR_W-1:0]  mem_rd,
    input  wire [`REG_ADDR_W-1:0]  wb_rd,
    input  wire                    ex_mem_read,
    input  wire                    mem_reg_write,
    input  wire                    wb_reg_write,
    input  wire                    branch_taken,
    input  wire                    halted,
    output logic                   stall,
    output logic                   flush,
    output rv_pkg::fwd_sel_e       fwd_a,
    output rv_pkg::fwd_sel_e       fwd_b
);
    import rv_pkg::*;

    logic load_use;

    // newest producer first, x0 is never forwarded
    function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_W-1:0] rs);
        fwd_sel_e sel;
        if (mem_reg_write && mem_rd != '0 && mem_rd == rs) begin
            sel = FWD_MEM;
        end else if (wb_reg_write && wb_rd != '0 && wb_rd == rs) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_RF;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_src(ex_rs1);
        fwd_b = pick_src(ex_rs2);
    end

    // load data arrives a cycle too late for the next instruction
    assign load_use = ex_mem_read && (ex_rd != '0) && (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign stall = load_use || halted;
    assign flush = branch_taken && !halted; // no redirect once frozen

    // a load and a taken branch never share the execute stage
    stall_flush_excl: assert property (@(posedge clk) disable iff (reset)
        !(stall && flush))
        else $error("load-use stall and branch flush in the same cycle");

    // the bubble put into execute clears the hazard
    load_use_one_cycle: assert property (@(posedge clk) disable iff (reset)
        load_use |=> !load_use)
        else $error("load-use stall longer than one cycle");

endmodule

`default_nettype wire

//--- pipe_reg.sv
// stage register with hold and bubble insertion, generic over its payload
`default_nettype none

module pipe_reg #(
    parameter type payload_t = rv_pkg::if_id_t
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      hold,   // keep the current payload
    input  wire      bubble, // load a no-op payload
    input  payload_t d,
    output payload_t q
);

    // bubble wins over hold so a flush can drop a stalled instruction
    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- rv_core.sv
// five-stage rv32i pipeline top with stage registers, control and halt flag
`default_nettype none

`include "rv_defines.svh"

module rv_core (
    input  wire               clk,
    input  wire               reset,
    output logic [`XLEN-1:0]  imem_addr,
    input  wire [`XLEN-1:0]   imem_data,
    output logic              wb_valid,
    output rv_pkg::wb_port_t  wb,
    output logic              halted
);
    import rv_pkg::*;

    if_id_t           if_id_d;
    if_id_t           if_id_q;
    id_ex_t           id_ex_d;
    id_ex_t           id_ex_q;
    ex_mem_t          ex_mem_d;
    ex_mem_t          ex_mem_q;
    mem_wb_t          mem_wb_d;
    mem_wb_t          mem_wb_q;
    logic             stall;
    logic             flush;
    logic             halt;   // ecall in writeback or already halted
    fwd_sel_e         fwd_a;
    fwd_sel_e         fwd_b;
    logic             branch_taken;
    logic [`XLEN-1:0] branch_target;
    logic [`XLEN-1:0] dmem_rdata;

    fetch_unit i_fetch (
        .clk, .reset, .stall, .halted(halt), .branch_taken, .branch_target,
        .imem_addr, .imem_data, .if_id(if_id_d)
    );

    pipe_reg #(.payload_t(if_id_t)) i_if_id (
        .clk, .reset, .hold(stall), .bubble(flush), .d(if_id_d), .q(if_id_q)
    );

    decode_unit i_decode (
        .clk, .reset, .if_id(if_id_q), .wb(mem_wb_q), .id_ex(id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk, .reset, .hold(1'b0), .bubble(stall || flush), .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit i_execute (
        .id_ex(id_ex_q), .fwd_a, .fwd_b, .mem_fwd(mem_wb_d.wb_data),
        .wb_fwd(mem_wb_q.wb_data), .ex_mem(ex_mem_d), .branch_taken, .branch_target
    );

    // younger instructions are dropped on halt
    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk, .reset, .hold(1'b0), .bubble(halt), .d(ex_mem_d), .q(ex_mem_q)
    );

    data_memory #(.depth(`DMEM_WORDS)) i_dmem (
        .clk, .we(ex_mem_q.mem_write && !halt), .addr(ex_mem_q.alu_out),
        .wdata(ex_mem_q.store_data), .rdata(dmem_rdata)
    );

    assign mem_wb_d.reg_write = ex_mem_q.reg_write;
    assign mem_wb_d.is_ecall  = ex_mem_q.is_ecall;
    assign mem_wb_d.wb_data   = ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.alu_out;
    assign mem_wb_d.rd        = ex_mem_q.rd;

    pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk, .reset, .hold(1'b0), .bubble(halt), .d(mem_wb_d), .q(mem_wb_q)
    );

    pipe_control i_control (
        .clk, .reset,
        .id_rs1(if_id_q.inst[19:15]), .id_rs2(if_id_q.inst[24:20]),
        .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2), .ex_rd(id_ex_q.rd),
        .mem_rd(ex_mem_q.rd), .wb_rd(mem_wb_q.rd),
        .ex_mem_read(id_ex_q.ctrl.mem_read), .mem_reg_write(ex_mem_q.reg_write),
        .wb_reg_write(mem_wb_q.reg_write), .branch_taken, .halted(halt),
        .stall, .flush, .fwd_a, .fwd_b
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (mem_wb_q.is_ecall) begin
            halted <= 1'b1; // sticky
        end
    end

    assign halt     = halted || mem_wb_q.is_ecall;
    assign wb_valid = mem_wb_q.reg_write && (mem_wb_q.rd != '0);
    assign wb.rd    = mem_wb_q.rd;
    assign wb.data  = mem_wb_q.wb_data;

endmodule

`default_nettype wire

//--- rv_core_stim.txt
// word 0 program length, word 1 number of expected writebacks, then the program words
// then one expected writeback per line, rd in the top two digits and data in the low eight
14
0b
00500093 // addi x1, x0, 5
ffd00113 // addi x2, x0, -3
402081b3 // sub  x3, x1, x2
40115233 // sra  x4, x2, x1
001122b3 // slt  x5, x2, x1
00113333 // sltu x6, x2, x1
00f1c393 // xori x7, x3, 15
00302223 // sw   x3, 4(x0)
00202423 // sw   x2, 8(x0)
00402403 // lw   x8, 4(x0)
001404b3 // add  x9, x8, x1
00802503 // lw   x10, 8(x0)
00948663 // beq  x9, x9, +12
00100593 // addi x11, x0, 1
00200613 // addi x12, x0, 2
00109463 // bne  x1, x1, +8
00451693 // slli x13, x10, 4
00000073 // ecall
00700713 // addi x14, x0, 7
00900793 // addi x15, x0, 9
0100000005
02fffffffd
0300000008
04ffffffff
0500000001
0600000000
0700000007
0800000008
090000000d
0afffffffd
0dffffffd0

//--- rv_defines.svh
// widths, memory depth, opcodes and funct3 codes of the rv32i core
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and register index widths
`define XLEN        32
`define REG_ADDR_W  5

// data memory depth in words
`define DMEM_WORDS  256

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_SYSTEM  7'b1110011

// funct3 of alu operations
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 of branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

`endif

//--- rv_pkg.sv
// alu and forwarding enums, control bundle and pipeline payload structs
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // all zero means no-op
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;   // second operand is the immediate
        logic    branch;
        logic    branch_ne; // bne instead of beq
        logic    is_ecall;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   is_ecall;
        logic [`XLEN-1:0]       alu_out;    // also the load/store address
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   is_ecall;
        logic [`XLEN-1:0]       wb_data;
        logic [`REG_ADDR_W-1:0] rd;
    } mem_wb_t;

    // retired register write seen outside the core
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_port_t;

endpackage

`default_nettype wire

//--- sources.f
+incdir+.
rv_pkg.sv
pipe_reg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
data_memory.sv
pipe_control.sv
rv_core.sv
tb_rv_core.sv

//--- tb_rv_core.sv
// testbench for rv_core with clock, reset, instruction memory model, writeback checks and watchdog
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int STIM_WORDS   = 64;
    localparam int IMEM_WORDS   = 64;
    localparam int HALF_PERIOD  = 20;
    localparam int DRIVE_DELAY  = 5;
    localparam int QUIET_CYCLES = 10;
    localparam int CYCLES_PER_WORD = 20;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    logic             wb_valid;
    wb_port_t         wb;
    logic             halted;

    logic [39:0]      stim [STIM_WORDS]; // {rd, data} or a program word
    logic [`XLEN-1:0] imem [IMEM_WORDS];
    int               prog_len;
    int               exp_count;
    int               exp_idx;
    logic             loaded = 1'b0;

    rv_core i_dut (
        .clk, .reset, .imem_addr, .imem_data, .wb_valid, .wb, .halted
    );

    assign imem_data = imem[imem_addr[7:2]]; // combinational fetch port

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task print_failure(input string line);
        $display("%s", line);
        $display("TB FAILED");
    endtask

    task load_program();
        $readmemh("rv_core_stim.txt", stim);
        prog_len  = int'(stim[0]);
        exp_count = int'(stim[1]);
        assert (prog_len <= IMEM_WORDS && 2 + prog_len + exp_count <= STIM_WORDS) else begin
            print_failure("stim file holds more words than the testbench can take");
            $fatal(1);
        end
        // addi x0, x0, index as filler
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {12'(i), 20'h00013};
        end
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = stim[2 + i][`XLEN-1:0];
        end
    endtask

    // compare one strobe with the next pair of the expected list
    task check_writeback();
        logic [39:0]             entry;
        logic [`REG_ADDR_W-1:0]  exp_rd;
        logic [`XLEN-1:0]        exp_data;
        assert (exp_idx < exp_count) else begin
            print_failure($sformatf("writeback to x%0d after the expected list was used up",
                                    wb.rd));
            $fatal(1);
        end
        entry    = stim[2 + prog_len + exp_idx];
        exp_rd   = entry[32 +: `REG_ADDR_W];
        exp_data = entry[`XLEN-1:0];
        assert (wb.rd == exp_rd) else begin
            print_failure($sformatf("FAIL wb.rd: expected %h, got %h (writeback %0d)",
                                    exp_rd, wb.rd, exp_idx));
            $fatal(1);
        end
        assert (wb.data == exp_data) else begin
            print_failure($sformatf("FAIL wb.data: expected %h, got %h (writeback %0d)",
                                    exp_data, wb.data, exp_idx));
            $fatal(1);
        end
        exp_idx++;
    endtask

    initial begin
        reset   = 1'b1;
        exp_idx = 0;
        load_program();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // outputs settle after the rising edge, sample on the falling one
        do begin
            @(negedge clk);
            if (wb_valid) begin
                check_writeback();
            end
        end while (!halted);

        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (!wb_valid) else begin
                print_failure($sformatf("FAIL wb_valid: expected %h, got %h after halt",
                                        1'b0, wb_valid));
                $fatal(1);
            end
        end

        assert (exp_idx == exp_count) else begin
            print_failure($sformatf("core halted after %0d of %0d expected writebacks",
                                    exp_idx, exp_count));
            $fatal(1);
        end
        $display("TB PASSED");
        $finish;
    end

    // watchdog sized from the program length
    initial begin
        int limit;
        wait (loaded);
        limit = prog_len * CYCLES_PER_WORD + 2 + QUIET_CYCLES;
        repeat (limit) @(posedge clk);
        print_failure($sformatf("timeout: the run did not finish within %0d cycles", limit));
        $fatal(1);
    end

endmodule

`default_nettype wire
